// ==== compile.f ====
logic/gluePkg.sv
logic/addressDecode.sv
logic/transferAck.sv
logic/ciaClock.sv
logic/tickGen.sv
logic/busGlue.sv
verification/busGlueTb.sv

// ==== logic/addressDecode.sv ====
// Address decode that latches the target region on transfer start and holds it until the ack ends
`timescale 1ns/10ps

module addressDecode (
    input logic clk40,
    input logic reset,
    input logic tsN,
    input logic ovl,
    input gluePkg::busAddress_u address,
    input logic [1:0] tt,
    input logic done,
    output gluePkg::decode_t decode,
    output logic cia0SelN,
    output logic cia1SelN
);

    import gluePkg::*;

    decode_t nextDecode;
    logic [15:0] high;
    logic [14:0] low;

    assign high = address.regionView.high;
    assign low = address.regionView.low;

    ////////////////////////////////////////
    // Region classification
    ////////////////////////////////////////

    always_comb begin
        nextDecode = '0;
        // Interrupt acknowledge beats any address
        if (tt == autovectorTt) begin
            nextDecode.region = autovector;
        end else if (high[15:3] == romBase[15:3]) begin
            nextDecode.region = rom;
        // Boot overlay maps ROM over low chip RAM
        end else if (ovl && high <= overlayTop) begin
            nextDecode.region = rom;
        end else if (high <= chipRamTop) begin
            nextDecode.region = chipRam;
        end else if (high == ciaHigh) begin
            nextDecode.region = cia;
        end else if (high == customHigh && low >= customLowMin) begin
            nextDecode.region = customReg;
        end

        nextDecode.romEn = (nextDecode.region == rom);
        nextDecode.ramSpace = (nextDecode.region == chipRam);
        nextDecode.regSpace = (nextDecode.region == customReg);
        // CIA-A on A12 low and CIA-B on A13 low
        if (nextDecode.region == cia) begin
            nextDecode.cia0Sel = !address.ciaView.ciaASelN;
            nextDecode.cia1Sel = !address.ciaView.ciaBSelN;
        end
    end

    // Hold from transfer start until the negate cycle
    always_ff @(posedge clk40) begin
        if (reset) begin
            decode <= '0;
        end else if (!tsN) begin
            decode <= nextDecode;
        end else if (done) begin
            decode <= '0;
        end
    end

    // Selects only ever come out of a cia decode
    assign cia0SelN = !(decode.cia0Sel && decode.region == cia);
    assign cia1SelN = !(decode.cia1Sel && decode.region == cia);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    ciaSelExclusive: assert property (
        @(posedge clk40) disable iff (reset)
        !(!cia0SelN && !cia1SelN)
    ) else $error("both CIA selects low");

    // New start only once the pending ack has finished
    noStartWhileBusy: assert property (
        @(posedge clk40) disable iff (reset)
        (!tsN && decode.region inside {rom, cia, autovector}) |-> done
    ) else $error("tsN during an active transfer");

endmodule

// ==== logic/busGlue.sv ====
// Bus glue top: region decode, transfer ack, CIA clock and ticks for the expansion bus
`timescale 1ns/10ps

module busGlue (
    input logic clk40,
    input logic reset,
    input logic tsN,
    input logic ovl,
    input gluePkg::busAddress_u address,
    input logic [1:0] tt,
    output logic romEnN,
    output logic bufEnN,
    output logic portSize,
    output logic cia0SelN,
    output logic cia1SelN,
    output logic ramSpaceN,
    output logic regSpaceN,
    output logic clkCia,
    output logic tick60,
    output logic tick50,
    inout wire tackN
);

    import gluePkg::*;

    decode_t decode;
    ackDrive_t ack;
    logic ciaStrobe;
    logic done;

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////

    addressDecode addressDecode (
        .clk40 (clk40),
        .reset (reset),
        .tsN (tsN),
        .ovl (ovl),
        .address (address),
        .tt (tt),
        .done (done),
        .decode (decode),
        .cia0SelN (cia0SelN),
        .cia1SelN (cia1SelN)
    );

    transferAck transferAck (
        .clk40 (clk40),
        .reset (reset),
        .decode (decode),
        .ciaStrobe (ciaStrobe),
        .ack (ack),
        .done (done)
    );

    ciaClock ciaClock (
        .clk40 (clk40),
        .reset (reset),
        .clkCia (clkCia),
        .ciaStrobe (ciaStrobe)
    );

    tickGen tickGen (
        .clk40 (clk40),
        .reset (reset),
        .ciaStrobe (ciaStrobe),
        .tick60 (tick60),
        .tick50 (tick50)
    );

    ////////////////////////////////////////
    // Pins
    ////////////////////////////////////////

    // Shared line, external pull-up when released
    assign tackN = ack.drive ? ack.level : 1'bz;

    assign romEnN = ~decode.romEn;
    assign ramSpaceN = ~decode.ramSpace;
    assign regSpaceN = ~decode.regSpace;
    // Data buffers open for any chipset access
    assign bufEnN = ~(decode.ramSpace | decode.regSpace);
    // Narrow ports: CIAs and custom registers
    assign portSize = (decode.region == cia) | decode.regSpace;

endmodule

// ==== logic/ciaClock.sv ====
// CIA clock: slow asymmetric peripheral clock from clk40 plus a falling-edge strobe
`timescale 1ns/10ps

module ciaClock (
    input logic clk40,
    input logic reset,
    output logic clkCia,
    output logic ciaStrobe
);

    import gluePkg::*;

    logic [ciaPhaseWidth-1:0] phase;
    logic [ciaPhaseWidth-1:0] phaseNext;
    logic lastPhase;

    ////////////////////////////////////////
    // Phase counter
    ////////////////////////////////////////

    // Phase 0 starts the low half
    assign lastPhase = (phase == ciaPhaseWidth'(ciaPeriod - 1));
    assign phaseNext = lastPhase ? '0 : phase + 1'b1;

    always_ff @(posedge clk40) begin
        if (reset) begin
            phase <= '0;
        end else begin
            phase <= phaseNext;
        end
    end

    // Registered so the pin never glitches
    always_ff @(posedge clk40) begin
        if (reset) begin
            clkCia <= 1'b0;
        end else begin
            clkCia <= (phaseNext >= ciaPhaseWidth'(ciaLowCycles));
        end
    end

    // High in the first low cycle, same edge that drops clkCia
    always_ff @(posedge clk40) begin
        if (reset) begin
            ciaStrobe <= 1'b0;
        end else begin
            ciaStrobe <= lastPhase;
        end
    end

    strobeSingle: assert property (
        @(posedge clk40) disable iff (reset)
        ciaStrobe |=> !ciaStrobe
    ) else $error("ciaStrobe longer than one cycle");

endmodule

// ==== logic/gluePkg.sv ====
// Bus glue shared definitions: target regions, address views, decode and ack bundles
package gluePkg;

    ////////////////////////////////////////
    // Timing
    ////////////////////////////////////////

    // ROM acknowledge delay after decode, in clk40 cycles
    localparam int romWaitStates = 3;
    localparam int waitCountWidth = $clog2(romWaitStates);
    // CIA clock phases in clk40 cycles
    localparam int ciaLowCycles = 24;
    localparam int ciaHighCycles = 16;
    localparam int ciaPeriod = ciaLowCycles + ciaHighCycles;
    localparam int ciaPhaseWidth = $clog2(ciaPeriod);
    // Tick half-periods in CIA clocks, scaled down but still 60:50
    localparam int tick60Half = 5;
    localparam int tick50Half = 6;
    localparam int tickCountWidth = $clog2(tick50Half);

    ////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////

    // High part is address bits 31..16
    // ROM covers 00F8 through 00FF, so only bits 15..3 of it are compared
    localparam logic [15:0] romBase = 16'h00F8;
    localparam logic [15:0] overlayTop = 16'h0007;
    localparam logic [15:0] chipRamTop = 16'h001F;
    localparam logic [15:0] ciaHigh = 16'h00BF;
    localparam logic [15:0] customHigh = 16'h00DF;
    // Byte offset F000, seen through bits 15..1
    localparam logic [14:0] customLowMin = 15'h7800;
    // Interrupt acknowledge transfer type
    localparam logic [1:0] autovectorTt = 2'd3;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        none = 3'd0,
        rom = 3'd1,
        chipRam = 3'd2,
        customReg = 3'd3,
        cia = 3'd4,
        autovector = 3'd5
    } region_e;

    // Coarse view for region decode
    typedef struct packed {
        logic [15:0] high;
        logic [14:0] low;
    } regionView_t;

    // CIA view, selects are low active
    typedef struct packed {
        logic [17:0] upper;
        logic ciaBSelN;
        logic ciaASelN;
        logic [3:0] regNum;
        logic [6:0] lower;
    } ciaView_t;

    // Address bits 31..1
    typedef union packed {
        regionView_t regionView;
        ciaView_t ciaView;
    } busAddress_u;

    typedef struct packed {
        region_e region;
        logic romEn;
        logic ramSpace;
        logic regSpace;
        logic cia0Sel;
        logic cia1Sel;
    } decode_t;

    typedef struct packed {
        logic drive;
        logic level;
    } ackDrive_t;

endpackage

// ==== logic/tickGen.sv ====
// Tick generator dividing CIA clock strobes into the 60 Hz and 50 Hz time-base waves
`timescale 1ns/10ps

module tickGen (
    input logic clk40,
    input logic reset,
    input logic ciaStrobe,
    output logic tick60,
    output logic tick50
);

    import gluePkg::*;

    // Index 0 is the 60 Hz wave and index 1 the 50 Hz wave
    logic [tickCountWidth-1:0] strobeCount [2];
    logic [1:0] tick;

    // Toggle once per half-period worth of strobes
    always_ff @(posedge clk40) begin
        if (reset) begin
            strobeCount[0] <= '0;
            strobeCount[1] <= '0;
            tick <= '0;
        end else if (ciaStrobe) begin
            for (int i = 0; i < 2; i++) begin
                if (strobeCount[i] ==
                        tickCountWidth'((i == 0 ? tick60Half : tick50Half) - 1)) begin
                    strobeCount[i] <= '0;
                    tick[i] <= ~tick[i];
                end else begin
                    strobeCount[i] <= strobeCount[i] + 1'b1;
                end
            end
        end
    end

    assign tick60 = tick[0];
    assign tick50 = tick[1];

endmodule

// ==== logic/transferAck.sv ====
// Transfer acknowledge: ROM wait states, CIA strobe sync, autovector ack, active negation
`timescale 1ns/10ps

module transferAck (
    input logic clk40,
    input logic reset,
    input gluePkg::decode_t decode,
    input logic ciaStrobe,
    output gluePkg::ackDrive_t ack,
    output logic done
);

    import gluePkg::*;

    typedef enum logic [1:0] {
        ackIdle,
        ackWait,
        ackAssert,
        ackNegate
    } ackState_e;

    ackState_e state;
    ackState_e nextState;
    logic [waitCountWidth-1:0] waitCount;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            ackIdle: begin
                case (decode.region)
                    rom: nextState = ackWait;
                    // Vector fetched internally, answer right away
                    autovector: nextState = ackAssert;
                    // Strobe may already land in the first decoded cycle
                    cia: nextState = ciaStrobe ? ackAssert : ackWait;
                    // RAM and custom space answered by the chipset
                    default: nextState = ackIdle;
                endcase
            end
            ackWait: begin
                if (decode.region == rom) begin
                    if (waitCount == waitCountWidth'(romWaitStates - 1)) begin
                        nextState = ackAssert;
                    end
                end else if (decode.region == cia) begin
                    if (ciaStrobe) begin
                        nextState = ackAssert;
                    end
                end else begin
                    // Region lost, nothing to answer
                    nextState = ackIdle;
                end
            end
            ackAssert: nextState = ackNegate;
            ackNegate: nextState = ackIdle;
            default: nextState = ackIdle;
        endcase
    end

    always_ff @(posedge clk40) begin
        if (reset) begin
            state <= ackIdle;
        end else begin
            state <= nextState;
        end
    end

    // Idle cycle after decode counts as the first wait state
    always_ff @(posedge clk40) begin
        if (reset || state == ackIdle) begin
            waitCount <= waitCountWidth'(1);
        end else if (state == ackWait) begin
            waitCount <= waitCount + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    // Low for one cycle, then driven high before release
    assign ack.drive = (state == ackAssert) || (state == ackNegate);
    assign ack.level = (state == ackNegate);
    // Clears the decode at the end of negation
    assign done = (state == ackNegate);

    noAckOnChipset: assert property (
        @(posedge clk40) disable iff (reset)
        (decode.region inside {chipRam, customReg}) |-> !ack.drive
    ) else $error("TACK driven in chipset space");

endmodule

// ==== verification/busGlueTb.sv ====
// Bus glue testbench driving bus cycles per region and checking the pins against a timing model
`timescale 1ns/10ps

module busGlueTb;

    import gluePkg::*;

    // Transfers issued by the stimulus
    localparam int romCount = 3;
    localparam int avCount = 2;
    localparam int ciaCount = 6;
    localparam int ramCount = 3;
    localparam int tickFalls = 2 * tick50Half * 3;
    localparam int cycleLimit = 16 + 20 * (romCount + avCount) + 2 * ciaPeriod * ciaCount
        + 25 * ramCount + tickFalls * ciaPeriod;

    logic clk40;
    logic reset;
    logic tsN;
    logic ovl;
    logic [1:0] tt;
    logic [31:0] byteAddr;
    busAddress_u address;
    logic romEnN;
    logic bufEnN;
    logic portSize;
    logic cia0SelN;
    logic cia1SelN;
    logic ramSpaceN;
    logic regSpaceN;
    logic clkCia;
    logic tick60;
    logic tick50;
    wire tackN;

    // Model state in sampled-edge terms
    region_e curRegion;
    region_e startRegion;
    int age;
    int ackAge;
    logic ciaSelA;
    logic ciaSelB;
    logic prevClkCia;
    logic ciaFall;
    int ciaCycle;
    int fallCount;
    int count60;
    int count50;
    logic expTick60;
    logic expTick50;
    int cycleCount = 0;
    integer seed = 29124;

    // Released line floats high
    pullup (tackN);

    assign address = byteAddr[31:1];

    busGlue UUT (
        .clk40 (clk40),
        .reset (reset),
        .tsN (tsN),
        .ovl (ovl),
        .address (address),
        .tt (tt),
        .romEnN (romEnN),
        .bufEnN (bufEnN),
        .portSize (portSize),
        .cia0SelN (cia0SelN),
        .cia1SelN (cia1SelN),
        .ramSpaceN (ramSpaceN),
        .regSpaceN (regSpaceN),
        .clkCia (clkCia),
        .tick60 (tick60),
        .tick50 (tick50),
        .tackN (tackN)
    );

    initial begin
        clk40 = 1'b0;
        forever #4 clk40 = ~clk40;
    end

    ////////////////////////////////////////
    // Memory map and failure helpers
    ////////////////////////////////////////

    function automatic region_e mapRegion(input logic [31:0] a, input logic [1:0] t,
                                          input logic o);
        logic [15:0] hi;
        hi = a[31:16];
        if (t == autovectorTt) return autovector;
        if (hi >= 16'h00F8 && hi <= 16'h00FF) return rom;
        // Overlay puts ROM over the bottom of chip RAM
        if (o && hi <= overlayTop) return rom;
        if (hi <= chipRamTop) return chipRam;
        if (hi == ciaHigh) return cia;
        if (hi == customHigh && a[15:0] >= 16'hF000) return customReg;
        return none;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic actual, input logic expected);
        abortRun($sformatf("MISMATCH at %0t: %s is %b, expected %b",
            $time, name, actual, expected));
    endtask

    ////////////////////////////////////////
    // Expected pin model
    ////////////////////////////////////////

    assign startRegion = mapRegion(byteAddr, tt, ovl);
    // Fall seen on the pin between two samples
    assign ciaFall = prevClkCia && !clkCia;

    always @(posedge clk40) begin
        if (reset) begin
            curRegion <= none;
            age <= 0;
            ackAge <= 0;
            ciaSelA <= 1'b0;
            ciaSelB <= 1'b0;
            prevClkCia <= 1'b0;
            ciaCycle <= 0;
            fallCount <= 0;
            count60 <= 0;
            count50 <= 0;
            expTick60 <= 1'b0;
            expTick50 <= 1'b0;
        end else begin
            prevClkCia <= clkCia;
            // Expected CIA clock phase, low half first
            ciaCycle <= (ciaCycle == ciaPeriod - 1) ? 0 : ciaCycle + 1;
            // Ticks trail the observed fall by one sample
            if (ciaFall) begin
                fallCount <= fallCount + 1;
                count60 <= (count60 == tick60Half - 1) ? 0 : count60 + 1;
                count50 <= (count50 == tick50Half - 1) ? 0 : count50 + 1;
                if (count60 == tick60Half - 1) expTick60 <= ~expTick60;
                if (count50 == tick50Half - 1) expTick50 <= ~expTick50;
            end
            if (!tsN) begin
                curRegion <= startRegion;
                age <= 1;
                ciaSelA <= !byteAddr[12];
                ciaSelB <= !byteAddr[13];
                case (startRegion)
                    rom: ackAge <= 1 + romWaitStates;
                    autovector: ackAge <= 2;
                    default: ackAge <= 0;
                endcase
            end else if (curRegion != none) begin
                age <= age + 1;
                // CIA ack one sample after the first fall past decode
                if (curRegion == cia && ackAge == 0 && ciaFall) ackAge <= age + 1;
                // Negation sample ends the transfer
                if (ackAge != 0 && age == ackAge + 1) begin
                    curRegion <= none;
                    ackAge <= 0;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Pin checks
    ////////////////////////////////////////

    clkCheck: assert property (@(posedge clk40) disable iff (reset)
        clkCia === (ciaCycle >= ciaLowCycles))
        else reportMismatch("clkCia", $sampled(clkCia),
            $sampled(ciaCycle >= ciaLowCycles));
    romEnCheck: assert property (@(posedge clk40) disable iff (reset)
        romEnN === (curRegion != rom))
        else reportMismatch("romEnN", $sampled(romEnN), $sampled(curRegion != rom));
    ramCheck: assert property (@(posedge clk40) disable iff (reset)
        ramSpaceN === (curRegion != chipRam))
        else reportMismatch("ramSpaceN", $sampled(ramSpaceN), $sampled(curRegion != chipRam));
    regCheck: assert property (@(posedge clk40) disable iff (reset)
        regSpaceN === (curRegion != customReg))
        else reportMismatch("regSpaceN", $sampled(regSpaceN), $sampled(curRegion != customReg));
    bufCheck: assert property (@(posedge clk40) disable iff (reset)
        bufEnN === !(curRegion inside {chipRam, customReg}))
        else reportMismatch("bufEnN", $sampled(bufEnN),
            $sampled(!(curRegion inside {chipRam, customReg})));
    sizeCheck: assert property (@(posedge clk40) disable iff (reset)
        portSize === (curRegion inside {cia, customReg}))
        else reportMismatch("portSize", $sampled(portSize),
            $sampled(curRegion inside {cia, customReg}));
    cia0Check: assert property (@(posedge clk40) disable iff (reset)
        cia0SelN === !(curRegion == cia && ciaSelA))
        else reportMismatch("cia0SelN", $sampled(cia0SelN),
            $sampled(!(curRegion == cia && ciaSelA)));
    cia1Check: assert property (@(posedge clk40) disable iff (reset)
        cia1SelN === !(curRegion == cia && ciaSelB))
        else reportMismatch("cia1SelN", $sampled(cia1SelN),
            $sampled(!(curRegion == cia && ciaSelB)));
    tackCheck: assert property (@(posedge clk40) disable iff (reset)
        tackN === !(curRegion != none && ackAge != 0 && age == ackAge))
        else reportMismatch("tackN", $sampled(tackN),
            $sampled(!(curRegion != none && ackAge != 0 && age == ackAge)));
    tick60Check: assert property (@(posedge clk40) disable iff (reset) tick60 === expTick60)
        else reportMismatch("tick60", $sampled(tick60), $sampled(expTick60));
    tick50Check: assert property (@(posedge clk40) disable iff (reset) tick50 === expTick50)
        else reportMismatch("tick50", $sampled(tick50), $sampled(expTick50));

    // Hang guard
    always @(posedge clk40) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) abortRun("timeout: run did not end within the cycle limit");
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // One-cycle start followed by the ack wait or a fixed window for chipset space
    task automatic busCycle(input logic [31:0] byteAddress, input logic [1:0] transferType,
                            input logic overlay);
        region_e target;
        target = mapRegion(byteAddress, transferType, overlay);
        @(negedge clk40);
        byteAddr = byteAddress;
        tt = transferType;
        ovl = overlay;
        tsN = 1'b0;
        @(negedge clk40);
        tsN = 1'b1;
        if (target inside {rom, cia, autovector}) begin
            while (tackN !== 1'b0) @(negedge clk40);
            // Active negation cycle
            @(negedge clk40);
        end else begin
            repeat (20) @(negedge clk40);
        end
    endtask

    initial begin
        logic [31:0] offset;
        int startFalls;
        reset = 1'b1;
        tsN = 1'b1;
        ovl = 1'b0;
        tt = 2'd0;
        byteAddr = '0;
        repeat (16) @(negedge clk40);
        reset = 1'b0;
        repeat (4) @(negedge clk40);
        // ROM, then overlay ROM, then the same low address as chip RAM
        busCycle(32'h00F8_0000, 2'd0, 1'b0);
        busCycle(32'h00FF_FFFC, 2'd2, 1'b0);
        busCycle(32'h0004_0000, 2'd1, 1'b1);
        busCycle(32'h0004_0000, 2'd1, 1'b0);
        busCycle(32'h001F_FFF0, 2'd0, 1'b0);
        busCycle(32'h00DF_F180, 2'd0, 1'b0);
        // CIA-A at BFExxx and CIA-B at BFDxxx in turn
        for (int i = 0; i < ciaCount; i++) begin
            offset = $random(seed);
            busCycle({16'h00BF, (i % 2 != 0 ? 4'hD : 4'hE), offset[3:0], 8'h01}, 2'd0, 1'b0);
        end
        // Interrupt acknowledge ignores the address
        busCycle(32'hFFFF_FFF6, autovectorTt, 1'b0);
        busCycle(32'h00F8_0000, autovectorTt, 1'b1);
        startFalls = fallCount;
        while (fallCount < startFalls + tickFalls) @(negedge clk40);
        repeat (2) @(negedge clk40);
        $display("all tests passed");
        $finish;
    end

endmodule
